//--- list.f
src/dphy_rx_pkg.sv
src/dphy_byte_align.sv
src/byte_fifo.sv
src/csi2_header_parser.sv
src/dphy_rx_lane.sv
verification/dphy_rx_lane_assertions.sv
verification/dphy_rx_lane_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the lane testbench with Verilator, then checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module dphy_rx_lane_tb -f list.f -o dphy_rx_lane_sim > sim.log 2>&1 \
  && ./obj_dir/dphy_rx_lane_sim >> sim.log 2>&1 \
  || echo "Some tests failed" >> sim.log

cat sim.log
if grep -q "Some tests failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
exit 0

//--- verification/dphy_rx_lane_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dphy_rx_lane_tb;

  import dphy_rx_pkg::*;

  logic         clk_i;
  logic         rst_i;
  logic [7:0]   lane_byte_i;
  logic         hs_data_valid_i;
  logic         reset_align_i;
  logic         header_valid_o;
  csi2_header_t header_o;
  logic         payload_valid_o;
  logic [7:0]   payload_o;
  logic         packet_done_o;
  logic         overflow_o;

  logic [15:0]  lfsr;
  csi2_header_t exp_hdr_q [$];
  logic [7:0]   exp_pay_q [$];
  logic         bit_q [$];
  csi2_header_t exp_h;
  logic [7:0]   exp_b;
  int           errors;
  int           done_count;
  int           pay_count;
  int           tests_run;
  int           tests_failed;

  dphy_rx_lane uut
  (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .lane_byte_i     (lane_byte_i),
    .hs_data_valid_i (hs_data_valid_i),
    .reset_align_i   (reset_align_i),
    .header_valid_o  (header_valid_o),
    .header_o        (header_o),
    .payload_valid_o (payload_valid_o),
    .payload_o       (payload_o),
    .packet_done_o   (packet_done_o),
    .overflow_o      (overflow_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial
  begin
    #2ms;
    $display("Watchdog expired before the test sequence finished");
    $display("Some tests failed");
    $finish;
  end

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[14:0], lfsr[15]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic push_byte(input logic [7:0] b);
    for (int i = 0; i < 8; i++)
      bit_q.push_back(b[i]); // Serial order is LSB first.
  endtask

  // Leader zeros, the bit offset, sync, header, payload and checksum.
  task automatic build_packet(input int offset, input logic [7:0] di, input int wc,
                              input bit sync_in_payload);
    logic [15:0] r;
    logic [7:0]  b;
    bit_q.delete();
    repeat (24 + offset) bit_q.push_back(1'b0);
    push_byte(SYNC_PATTERN);
    push_byte(di);
    push_byte(wc[7:0]);
    push_byte(wc[15:8]);
    draw(8, r);
    push_byte(r[7:0]);
    exp_hdr_q.push_back(csi2_header_t'{data_id: di, word_count: wc[15:0]});
    if (di >= SHORT_PACKET_MAX_DI)
    begin
      for (int i = 0; i < wc; i++)
      begin
        draw(8, r);
        b = (sync_in_payload && i % 3 == 1) ? SYNC_PATTERN : r[7:0];
        push_byte(b);
        exp_pay_q.push_back(b);
      end
      repeat (2)
      begin
        draw(8, r);
        push_byte(r[7:0]);
      end
    end
    while (bit_q.size() % 8 != 0)
      bit_q.push_back(1'b0);
    repeat (24) bit_q.push_back(1'b0); // Trailer flushes the aligner pipeline.
  endtask

  task automatic drive_burst(input int max_bytes);
    logic [7:0] b;
    int         n;
    n = 0;
    @(posedge clk_i);
    reset_align_i <= 1'b1;
    @(posedge clk_i);
    reset_align_i <= 1'b0;
    while (bit_q.size() >= 8 && n < max_bytes)
    begin
      for (int i = 0; i < 8; i++)
        b[i] = bit_q.pop_front();
      @(posedge clk_i);
      lane_byte_i     <= b;
      hs_data_valid_i <= 1'b1;
      n++;
    end
    @(posedge clk_i);
    lane_byte_i     <= '0;
    hs_data_valid_i <= 1'b0;
  endtask

  task automatic wait_done(input int target);
    int t;
    t = 0;
    while (done_count < target && t < 300)
    begin
      @(posedge clk_i);
      t++;
    end
    if (done_count < target)
    begin
      $display("Timeout while waiting for packet_done_o");
      errors++;
    end
  endtask

  task automatic run_packet(input int offset, input logic [7:0] di, input int wc,
                            input bit sync_in_payload);
    int d0;
    d0 = done_count;
    build_packet(offset, di, wc, sync_in_payload);
    drive_burst(1000);
    wait_done(d0 + 1);
    if (exp_hdr_q.size() != 0 || exp_pay_q.size() != 0)
    begin
      $display("Packet ended with expected header or payload bytes still missing");
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (overflow_o)
    begin
      $display("FIFO overflow flag was set during the test");
      errors++;
    end
    if (errors != err_before)
    begin
      tests_failed++;
      $display("Test %0s: FAIL", name);
    end
    else
      $display("Test %0s: ok", name);
  endtask

  // Output checker, sampled away from the driving edge.
  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (header_valid_o)
      begin
        if (exp_hdr_q.size() == 0)
        begin
          $display("Header pulse arrived with no packet outstanding");
          errors++;
        end
        else
        begin
          exp_h = exp_hdr_q.pop_front();
          assert (header_o == exp_h)
          else
          begin
            $display("MISMATCH header_o: got %h, expected %h", header_o, exp_h);
            errors++;
          end
          if (exp_h.data_id < SHORT_PACKET_MAX_DI)
            assert (packet_done_o)
            else
            begin
              $display("Short packet header came without packet_done_o");
              errors++;
            end
        end
      end
      if (payload_valid_o)
      begin
        pay_count++;
        if (exp_pay_q.size() == 0)
        begin
          $display("Payload byte arrived that no packet carries");
          errors++;
        end
        else
        begin
          exp_b = exp_pay_q.pop_front();
          assert (payload_o == exp_b)
          else
          begin
            $display("MISMATCH payload_o: got %h, expected %h", payload_o, exp_b);
            errors++;
          end
        end
      end
      if (packet_done_o)
        done_count++;
    end
  end

  initial
  begin
    logic [15:0] r;
    int          e0;
    int          c;
    rst_i           = 1'b1;
    lane_byte_i     = '0;
    hs_data_valid_i = 1'b0;
    reset_align_i   = 1'b0;
    lfsr            = 16'd53802;
    errors          = 0;
    done_count      = 0;
    pay_count       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    e0 = errors;
    for (int k = 0; k < 8; k++)
    begin
      draw(8, r);
      c = r[3:0] + 1;
      run_packet(k, r[7:0] | 8'h10, c, 1'b0);
    end
    finish_test("alignment at every offset", e0);

    e0 = errors;
    draw(16, r);
    run_packet(3, r[7:0] & 8'h0f, {16'd0, r}, 1'b0);
    finish_test("short packet", e0);

    e0 = errors;
    run_packet(2, 8'h2c, 12, 1'b1);
    run_packet(6, 8'h1e, 5, 1'b0);
    finish_test("lock hold and re-arm", e0);

    e0 = errors;
    build_packet(5, 8'h2b, 16, 1'b0);
    drive_burst(17);
    repeat (10) @(posedge clk_i);
    c = pay_count;
    repeat (20) @(posedge clk_i);
    if (pay_count != c)
    begin
      $display("payload_valid_o kept pulsing after the burst ended");
      errors++;
    end
    if (exp_hdr_q.size() != 0 || exp_pay_q.size() == 0)
    begin
      $display("Cut burst did not deliver a header and a partial payload");
      errors++;
    end
    exp_pay_q.delete();
    run_packet(1, 8'h24, 7, 1'b0);
    finish_test("burst end", e0);

    e0 = errors;
    build_packet(5, 8'h2b, 16, 1'b0);
    drive_burst(17);
    rst_i <= 1'b1; // Payload bytes are still on their way through the FIFO here.
    @(posedge clk_i);
    @(negedge clk_i);
    if (header_valid_o || payload_valid_o || packet_done_o || overflow_o)
    begin
      $display("Outputs still active after reset");
      errors++;
    end
    exp_hdr_q.delete();
    exp_pay_q.delete();
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    c = pay_count;
    repeat (20) @(posedge clk_i);
    if (pay_count != c)
    begin
      $display("Payload bytes from before the reset came out after it");
      errors++;
    end
    finish_test("reset behavior", e0);

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/dphy_rx_lane_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module dphy_rx_lane_assertions
(
  input logic clk_i,
  input logic rst_i,
  input logic header_valid_o,
  input logic payload_valid_o,
  input logic packet_done_o,
  input logic overflow_o
);

  logic between_packets; // High from packet_done_o until the next header.

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      between_packets <= 1'b1;
    else if (packet_done_o)
      between_packets <= 1'b1;
    else if (header_valid_o)
      between_packets <= 1'b0;
  end

  quiet_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !header_valid_o && !payload_valid_o && !packet_done_o && !overflow_o)
    else $error("Outputs active right after reset");

  no_payload_between_packets: assert property (@(posedge clk_i) disable iff (rst_i)
    payload_valid_o |-> !between_packets)
    else $error("Payload byte outside of a packet");

  done_apart_from_payload: assert property (@(posedge clk_i) disable iff (rst_i)
    !(packet_done_o && payload_valid_o))
    else $error("Packet end together with a payload byte");

  overflow_sticky: assert property (@(posedge clk_i)
    (!rst_i && overflow_o) |=> overflow_o)
    else $error("Overflow flag cleared without reset");

endmodule

bind dphy_rx_lane dphy_rx_lane_assertions u_assert
(
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .header_valid_o  (header_valid_o),
  .payload_valid_o (payload_valid_o),
  .packet_done_o   (packet_done_o),
  .overflow_o      (overflow_o)
);

`default_nettype wire

//--- src/dphy_rx_lane.sv
`timescale 1ns/100ps
`default_nettype none

module dphy_rx_lane
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [7:0]                lane_byte_i,
  input  logic                      hs_data_valid_i,
  input  logic                      reset_align_i,
  output logic                      header_valid_o,
  output dphy_rx_pkg::csi2_header_t header_o,
  output logic                      payload_valid_o,
  output logic [7:0]                payload_o,
  output logic                      packet_done_o,
  output logic                      overflow_o
);

  import dphy_rx_pkg::*;

  lane_byte_t aligned;
  logic       aligned_valid;
  lane_byte_t fifo_head;
  logic       fifo_not_empty;
  logic       fifo_pop;

  dphy_byte_align u_align
  (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .unaligned_byte_i (lane_byte_i),
    .hs_data_valid_i  (hs_data_valid_i),
    .reset_align_i    (reset_align_i),
    .valid_o          (aligned_valid),
    .aligned_o        (aligned)
  );

  byte_fifo #(.payload_t(lane_byte_t)) u_fifo
  (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .write_i      (aligned_valid),
    .write_data_i (aligned),
    .read_i       (fifo_pop),
    .read_data_o  (fifo_head),
    .not_empty_o  (fifo_not_empty),
    .overflow_o   (overflow_o)
  );

  csi2_header_parser u_parser
  (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .byte_present_i  (fifo_not_empty),
    .byte_i          (fifo_head),
    .pop_o           (fifo_pop),
    .header_valid_o  (header_valid_o),
    .header_o        (header_o),
    .payload_valid_o (payload_valid_o),
    .payload_o       (payload_o),
    .packet_done_o   (packet_done_o)
  );

endmodule

`default_nettype wire

//--- src/csi2_header_parser.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_header_parser
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      byte_present_i,
  input  dphy_rx_pkg::lane_byte_t   byte_i,
  output logic                      pop_o,
  output logic                      header_valid_o,
  output dphy_rx_pkg::csi2_header_t header_o,
  output logic                      payload_valid_o,
  output logic [7:0]                payload_o,
  output logic                      packet_done_o
);

  import dphy_rx_pkg::*;

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_HEADER,
    ST_PAYLOAD,
    ST_CHECKSUM
  } state_t;

  state_t       state;
  logic [1:0]   hdr_idx;
  csi2_header_t hdr_q;
  logic [15:0]  remaining;
  logic         crc_second;
  logic         is_short;
  logic         plain_byte;
  logic         header_done;
  logic         payload_byte;

  assign pop_o = byte_present_i; // No stall ever reaches the FIFO.

  assign is_short     = hdr_q.data_id < SHORT_PACKET_MAX_DI;
  assign plain_byte   = byte_present_i && !byte_i.sot;
  assign header_done  = plain_byte && state == ST_HEADER && hdr_idx == 2'd3;
  assign payload_byte = plain_byte && state == ST_PAYLOAD;

  // Header bytes are data identifier, word count low, word count high, ECC.
  always_ff @(posedge clk_i)
  begin
    if (byte_present_i && byte_i.sot)
      hdr_q.data_id <= byte_i.data;
    else if (plain_byte && state == ST_HEADER && hdr_idx == 2'd1)
      hdr_q.word_count[7:0] <= byte_i.data;
    else if (plain_byte && state == ST_HEADER && hdr_idx == 2'd2)
      hdr_q.word_count[15:8] <= byte_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (header_done)
      header_o <= hdr_q;
    if (payload_byte)
      payload_o <= byte_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state           <= ST_IDLE;
      hdr_idx         <= '0;
      remaining       <= '0;
      crc_second      <= 1'b0;
      header_valid_o  <= 1'b0;
      payload_valid_o <= 1'b0;
      packet_done_o   <= 1'b0;
    end
    else
    begin
      header_valid_o  <= header_done;
      payload_valid_o <= payload_byte;
      packet_done_o   <= 1'b0;
      if (byte_present_i && byte_i.sot)
      begin
        state   <= ST_HEADER; // A new burst aborts whatever packet was open.
        hdr_idx <= 2'd1;
      end
      else if (byte_present_i)
      begin
        case (state)
          ST_HEADER:
          begin
            hdr_idx <= hdr_idx + 1'b1;
            if (header_done)
            begin
              if (is_short)
              begin
                state         <= ST_IDLE;
                packet_done_o <= 1'b1;
              end
              else if (hdr_q.word_count == '0)
              begin
                state      <= ST_CHECKSUM;
                crc_second <= 1'b0;
              end
              else
              begin
                state     <= ST_PAYLOAD;
                remaining <= hdr_q.word_count;
              end
            end
          end
          ST_PAYLOAD:
          begin
            remaining <= remaining - 1'b1;
            if (remaining == 16'd1)
            begin
              state      <= ST_CHECKSUM;
              crc_second <= 1'b0;
            end
          end
          ST_CHECKSUM:
          begin
            if (crc_second)
            begin
              state         <= ST_IDLE;
              packet_done_o <= 1'b1;
            end
            else
            begin
              crc_second <= 1'b1;
            end
          end
          default:
          begin
            state <= ST_IDLE; // stray bytes outside a packet are dropped
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- src/byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module byte_fifo
#(
  parameter type payload_t = dphy_rx_pkg::lane_byte_t
)
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     write_i,
  input  payload_t write_data_i,
  input  logic     read_i,
  output payload_t read_data_o,
  output logic     not_empty_o,
  output logic     overflow_o
);

  import dphy_rx_pkg::*;

  payload_t               mem [FIFO_DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr;
  logic [FIFO_ADDR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0]  count;
  logic                   head_valid;
  payload_t               head_data;
  logic                   head_load;
  logic                   mem_full;
  logic                   mem_push;

  function automatic logic [FIFO_ADDR_W-1:0] next_ptr
  (
    input logic [FIFO_ADDR_W-1:0] ptr
  );
    if (ptr == FIFO_ADDR_W'(FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // The head register refills from memory when it is empty or being read.
  assign head_load = (!head_valid || read_i) && (count != '0);
  assign mem_full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign mem_push  = write_i && (!mem_full || head_load);

  always_ff @(posedge clk_i)
  begin
    if (mem_push)
      mem[wr_ptr] <= write_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (head_load)
      head_data <= mem[rd_ptr];
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      head_valid <= 1'b0;
      overflow_o <= 1'b0;
    end
    else
    begin
      if (mem_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (head_load)
        rd_ptr <= next_ptr(rd_ptr);
      if (mem_push && !head_load)
        count <= count + 1'b1;
      else if (!mem_push && head_load)
        count <= count - 1'b1;
      if (head_load)
        head_valid <= 1'b1;
      else if (read_i)
        head_valid <= 1'b0;
      if (write_i && !mem_push)
        overflow_o <= 1'b1; // Sticky until reset.
    end
  end

  assign read_data_o = head_data;
  assign not_empty_o = head_valid;

endmodule

`default_nettype wire

//--- src/dphy_byte_align.sv
`timescale 1ns/100ps
`default_nettype none

module dphy_byte_align
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [7:0]              unaligned_byte_i,
  input  logic                    hs_data_valid_i,
  input  logic                    reset_align_i,
  output logic                    valid_o,
  output dphy_rx_pkg::lane_byte_t aligned_o
);

  import dphy_rx_pkg::*;

  logic [7:0]  byte_d1;
  logic [7:0]  byte_d2;
  logic [15:0] window;
  logic        sync_found;
  logic [2:0]  sync_shift;
  logic        locked;
  logic [2:0]  shift_q;
  logic        sot_pending;
  logic        emit;
  logic [7:0]  aligned_data_q;
  logic        aligned_sot_q;

  always_ff @(posedge clk_i)
  begin
    byte_d1 <= unaligned_byte_i;
    byte_d2 <= byte_d1;
  end

  assign window = {byte_d1, byte_d2}; // Older byte in the low half, bits arrive LSB first.

  // Lowest matching shift wins since the loop runs downwards.
  always_comb
  begin
    sync_found = 1'b0;
    sync_shift = '0;
    for (int i = 7; i >= 0; i--)
    begin
      if (hs_data_valid_i && window[i +: 8] == SYNC_PATTERN)
      begin
        sync_found = 1'b1;
        sync_shift = 3'(i);
      end
    end
  end

  assign emit = locked && hs_data_valid_i && !reset_align_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      locked      <= 1'b0;
      shift_q     <= '0;
      sot_pending <= 1'b0;
    end
    else if (reset_align_i)
    begin
      locked      <= 1'b0;
      sot_pending <= 1'b0;
    end
    else if (!locked && sync_found)
    begin
      locked      <= 1'b1;
      shift_q     <= sync_shift;
      sot_pending <= 1'b1; // The byte after the sync byte opens the burst.
    end
    else if (emit)
    begin
      sot_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_o       <= 1'b0;
      aligned_sot_q <= 1'b0;
    end
    else
    begin
      valid_o       <= emit;
      aligned_sot_q <= emit && sot_pending;
    end
  end

  always_ff @(posedge clk_i)
  begin
    aligned_data_q <= window[shift_q +: 8];
  end

  assign aligned_o = '{data: aligned_data_q, sot: aligned_sot_q};

endmodule

`default_nettype wire

//--- src/dphy_rx_pkg.sv
`default_nettype none

package dphy_rx_pkg;

  // Leader sequence byte that opens every high-speed burst on the lane.
  localparam logic [7:0] SYNC_PATTERN = 8'b1011_1000;

  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1); // Holds 0 up to FIFO_DEPTH.

  // Data identifiers below this value carry no payload.
  localparam logic [7:0] SHORT_PACKET_MAX_DI = 8'h10;

  // One aligned byte from the lane.
  typedef struct packed
  {
    logic [7:0] data;
    logic       sot;  // First byte after the sync byte.
  } lane_byte_t;

  // Decoded CSI-2 packet header.
  typedef struct packed
  {
    logic [7:0]  data_id;     // Virtual channel and data type.
    logic [15:0] word_count;  // Payload length in bytes.
  } csi2_header_t;

endpackage

`default_nettype wire
